// File: logic/useq_config.svh
//////////////////////////////////////////////////////////////////////
// widths and microinstruction field positions, one value each
// field macros give the low bit of a multi-bit field
//////////////////////////////////////////////////////////////////////
`ifndef USEQ_CONFIG_SVH
`define USEQ_CONFIG_SVH

`define UPC_WIDTH       14
`define UINST_WIDTH     49
`define SPC_DEPTH_LOG2  5
`define COND_WIDTH      8
`define SPC_WIDTH       `UPC_WIDTH

`define FLD_INVERT      6
`define FLD_N           7
`define FLD_CALL        8
`define FLD_RET         9
`define FLD_NOP11       11
`define FLD_POPJ        42
`define FLD_TYPE        43
`define FLD_TARGET      12
`define FLD_COND        0
`define FLD_DN          41
`define FLD_DP          40
`define FLD_DR          39
`define FLD_SRC         32
`define FLD_DEST        35

// alu-type source and destination codes
`define SRC_SPC         1
`define SRC_SPC_POP     2
`define DEST_SPC        1

`endif

// File: logic/useq_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared sequencer types, widths come from useq_config.svh
//////////////////////////////////////////////////////////////////////
`include "useq_config.svh"

package useq_pkg;

   typedef logic [`UPC_WIDTH-1:0]      upc_t;      // microcode address
   typedef logic [`UINST_WIDTH-1:0]    uinst_t;    // microinstruction word
   typedef logic [`SPC_DEPTH_LOG2-1:0] spc_ptr_t;  // stack pointer
   typedef logic [`COND_WIDTH-1:0]     cond_t;     // condition flags

   // one microinstruction = alu, write, fetch
   typedef enum logic [1:0]
   {
      cyc_alu,
      cyc_write,
      cyc_fetch
   } cyc_state_t;

   // next address select, same coding as the pcs1/pcs0 pair
   typedef logic [1:0] pc_sel_t;

   localparam pc_sel_t PCS_STACK = 2'd0;
   localparam pc_sel_t PCS_JUMP  = 2'd1;
   localparam pc_sel_t PCS_DISP  = 2'd2;
   localparam pc_sel_t PCS_INC   = 2'd3;

endpackage

// File: logic/cycle_sequencer.sv
//////////////////////////////////////////////////////////////////////
// free-running, never stalls; starts in the alu cycle after reset
//////////////////////////////////////////////////////////////////////
module cycle_sequencer
   import useq_pkg::*;
(
   input  logic clk,
   input  logic reset,
   output logic state_alu,
   output logic state_write,
   output logic state_fetch
);

   cyc_state_t state;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= cyc_alu;
      else
      begin
         case (state)
            cyc_alu:   state <= cyc_write;
            cyc_write: state <= cyc_fetch;
            cyc_fetch: state <= cyc_alu;
            default:   state <= cyc_alu;   // unused code, recover
         endcase
      end
   end

   // one-hot strobes
   assign state_alu   = (state == cyc_alu);
   assign state_write = (state == cyc_write);
   assign state_fetch = (state == cyc_fetch);

endmodule

// File: logic/uinst_decode.sv
//////////////////////////////////////////////////////////////////////
// type code 3 decodes as alu; funct shares bit 11 with nop11
// dispatch target is the jump target field, no dispatch memory
//////////////////////////////////////////////////////////////////////
`include "useq_config.svh"

module uinst_decode
   import useq_pkg::*;
(
   input  uinst_t     uinst,
   input  cond_t      cond_flags,
   output logic       irjump,
   output logic       irdisp,
   output logic       ir_invert,
   output logic       ir_n,
   output logic       ir_call,
   output logic       ir_ret,
   output logic       popj_bit,
   output logic       nop11,
   output logic       dn,
   output logic       dp,
   output logic       dr,
   output logic       destspc,
   output logic       srcspc,
   output logic       srcspcpop,
   output logic       jcond,
   output logic [3:0] funct,
   output upc_t       target
);

   logic [1:0] utype;
   logic       iralu;
   logic [2:0] src_code;
   logic [2:0] dest_code;
   logic [2:0] cond_sel;
   logic [1:0] funct_code;

   assign utype     = uinst[`FLD_TYPE +: 2];
   assign irjump    = (utype == 2'd1);
   assign irdisp    = (utype == 2'd2);
   assign iralu     = ~irjump & ~irdisp;   // codes 0 and 3

   // jump word control bits
   assign ir_invert = uinst[`FLD_INVERT];
   assign ir_n      = uinst[`FLD_N];
   assign ir_call   = uinst[`FLD_CALL];
   assign ir_ret    = uinst[`FLD_RET];
   assign popj_bit  = uinst[`FLD_POPJ];
   assign nop11     = uinst[`FLD_NOP11];

   // dispatch bits, taken straight from the word
   assign dn = uinst[`FLD_DN];
   assign dp = uinst[`FLD_DP];
   assign dr = uinst[`FLD_DR];

   assign funct_code = uinst[`FLD_NOP11 -: 2];
   assign funct      = 4'b0001 << funct_code;   // one-hot

   // stack access from alu words only
   assign src_code  = uinst[`FLD_SRC +: 3];
   assign dest_code = uinst[`FLD_DEST +: 3];
   assign srcspc    = iralu & (src_code == 3'(`SRC_SPC));
   assign srcspcpop = iralu & (src_code == 3'(`SRC_SPC_POP));
   assign destspc   = iralu & (dest_code == 3'(`DEST_SPC));

   assign cond_sel = uinst[`FLD_COND +: 3];
   assign jcond    = cond_flags[cond_sel];   // sense applied later

   assign target = uinst[`FLD_TARGET +: `UPC_WIDTH];

endmodule

// File: logic/seq_control.sv
//////////////////////////////////////////////////////////////////////
// pc select and stack control; inop and iwrited load on fetch
// call and return together in a jump is the microcode write form
//////////////////////////////////////////////////////////////////////
module seq_control
   import useq_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       state_alu,
   input  logic       state_write,
   input  logic       state_fetch,
   input  logic       trap,
   input  logic       irjump,
   input  logic       irdisp,
   input  logic       ir_invert,
   input  logic       ir_n,
   input  logic       ir_call,
   input  logic       ir_ret,
   input  logic       popj_bit,
   input  logic       nop11,
   input  logic       dn,
   input  logic       dp,
   input  logic       dr,
   input  logic       destspc,
   input  logic       srcspc,
   input  logic       srcspcpop,
   input  logic       jcond,
   input  logic [3:0] funct,
   output pc_sel_t    pcs,
   output logic       n,
   output logic       nop,
   output logic       nopa,
   output logic       iwrited,
   output logic       spush,
   output logic       spop,
   output logic       swp,
   output logic       srp,
   output logic       spcnt,
   output logic       spcdrive,
   output logic       spcenb,
   output logic       srcspcpopreal
);

   logic inop;
   logic dispenb;
   logic dfall;
   logic ignpopj;
   logic jtaken;    // jump condition met, either sense
   logic jret;
   logic iwrite;
   logic popj;

   //////////////////////////////////////////////////////////////////////
   // word decode
   //////////////////////////////////////////////////////////////////////

   assign dispenb = irdisp & ~funct[2];
   assign dfall   = dr & dp;                  // push and pop cancel
   assign ignpopj = irdisp & ~dr;

   assign jtaken = irjump & (jcond ^ ir_invert);
   assign jret   = irjump & ~ir_call & ir_ret;
   assign iwrite = irjump & ir_call & ir_ret;  // microcode write

   assign popj          = (popj_bit & ~nop) | iwrited;  // delayed return after write
   assign srcspcpopreal = srcspcpop & ~nop;

   //////////////////////////////////////////////////////////////////////
   // stack control
   //////////////////////////////////////////////////////////////////////

   assign spop = ((srcspcpopreal | popj) & ~ignpopj) |
                 (dispenb & dr & ~dp) |
                 (jret & jtaken);

   assign spush = destspc |
                  (dispenb & dp & ~dr) |
                  (jtaken & ir_call);

   assign swp      = spush & state_write;   // data written in the write cycle
   assign srp      = state_fetch;           // pointer moves at end of fetch
   assign spcnt    = spush | spop;
   assign spcenb   = srcspc | srcspcpop;
   assign spcdrive = spcenb & (state_alu | state_write | state_fetch);

   //////////////////////////////////////////////////////////////////////
   // next address and N
   //////////////////////////////////////////////////////////////////////

   // 0 stack, 1 target, 2 dispatch, 3 increment
   assign pcs[1] = ~((popj & ~ignpopj) |
                     jtaken |
                     (dispenb & dr & ~dp));

   assign pcs[0] = ~(popj |
                     (dispenb & ~dfall) |
                     (jret & jtaken));

   assign n = trap |
              iwrited |
              (dispenb & dn) |
              (jtaken & ir_n);

   assign nopa = inop | nop11;
   assign nop  = trap | nopa;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         inop    <= 1'b0;
         iwrited <= 1'b0;
      end
      else if (state_fetch)
      begin
         inop    <= n;        // cancels the next word
         iwrited <= iwrite;
      end
   end

endmodule

// File: logic/spc_stack.sv
//////////////////////////////////////////////////////////////////////
// 32-entry return stack, pointer wraps; no overflow detection
// top is registered, valid from the write cycle of the next word
//////////////////////////////////////////////////////////////////////
`include "useq_config.svh"

module spc_stack
   import useq_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     spush,
   input  logic     spop,
   input  logic     swp,
   input  logic     srp,
   input  logic     destspc,
   input  upc_t     write_data,
   input  upc_t     ret_addr,
   output upc_t     spc_top,
   output spc_ptr_t spc_ptr
);

   localparam int stack_depth = 1 << `SPC_DEPTH_LOG2;

   logic [`SPC_WIDTH-1:0] stack_mem [stack_depth];
   upc_t                  push_data;
   spc_ptr_t              ptr_inc;

   assign ptr_inc   = spc_ptr + spc_ptr_t'(1);
   assign push_data = destspc ? write_data : ret_addr;   // data push or call

   // entry above the pointer, written in the write cycle
   always_ff @(posedge clk)
   begin
      if (swp)
         stack_mem[ptr_inc] <= push_data;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         spc_ptr <= '0;
      else if (srp)
      begin
         if (spush)
            spc_ptr <= ptr_inc;               // push wins
         else if (spop)
            spc_ptr <= spc_ptr - spc_ptr_t'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      spc_top <= stack_mem[spc_ptr];
   end

endmodule

// File: logic/upc_select.sv
//////////////////////////////////////////////////////////////////////
// address register, loads only on fetch
// dispatch and jump both take the target field
//////////////////////////////////////////////////////////////////////
module upc_select
   import useq_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    state_fetch,
   input  pc_sel_t pcs,
   input  upc_t    target,
   input  upc_t    spc_top,
   output upc_t    upc,
   output upc_t    upc_next_inc
);

   upc_t upc_next;

   assign upc_next_inc = upc + upc_t'(1);   // also the call return address

   always_comb
   begin
      case (pcs)
         PCS_STACK: upc_next = spc_top;
         PCS_JUMP:  upc_next = target;
         PCS_DISP:  upc_next = target;      // no dispatch memory
         PCS_INC:   upc_next = upc_next_inc;
         default:   upc_next = upc_next_inc;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         upc <= '0;
      else if (state_fetch)
         upc <= upc_next;
   end

endmodule

// File: logic/useq_top.sv
//////////////////////////////////////////////////////////////////////
// uinst and cond_flags must hold from one fetch to the next
// spc_data reads zero unless the word sources the stack
//////////////////////////////////////////////////////////////////////
module useq_top
   import useq_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   trap,
   input  uinst_t uinst,
   input  cond_t  cond_flags,
   input  upc_t   write_data,
   output upc_t   upc,
   output upc_t   spc_data,
   output logic   nop,
   output logic   fetch
);

   logic       state_alu, state_write, state_fetch;
   logic       irjump, irdisp, ir_invert, ir_n, ir_call, ir_ret;
   logic       popj_bit, nop11, dn, dp, dr, jcond;
   logic       destspc, srcspc, srcspcpop;
   logic [3:0] funct;
   upc_t       target;
   pc_sel_t    pcs;
   logic       spush, spop, swp, srp, spcdrive;
   upc_t       spc_top;
   upc_t       upc_next_inc;

   cycle_sequencer i_cycle (
      .clk         (clk),
      .reset       (reset),
      .state_alu   (state_alu),
      .state_write (state_write),
      .state_fetch (state_fetch)
   );

   uinst_decode i_decode (
      .uinst (uinst), .cond_flags (cond_flags),
      .irjump (irjump), .irdisp (irdisp), .ir_invert (ir_invert), .ir_n (ir_n),
      .ir_call (ir_call), .ir_ret (ir_ret), .popj_bit (popj_bit), .nop11 (nop11),
      .dn (dn), .dp (dp), .dr (dr), .destspc (destspc), .srcspc (srcspc),
      .srcspcpop (srcspcpop), .jcond (jcond), .funct (funct), .target (target)
   );

   seq_control i_control (
      .clk (clk), .reset (reset), .state_alu (state_alu), .state_write (state_write),
      .state_fetch (state_fetch), .trap (trap), .irjump (irjump), .irdisp (irdisp),
      .ir_invert (ir_invert), .ir_n (ir_n), .ir_call (ir_call), .ir_ret (ir_ret),
      .popj_bit (popj_bit), .nop11 (nop11), .dn (dn), .dp (dp), .dr (dr),
      .destspc (destspc), .srcspc (srcspc), .srcspcpop (srcspcpop), .jcond (jcond),
      .funct (funct), .pcs (pcs), .n (), .nop (nop), .nopa (), .iwrited (),
      .spush (spush), .spop (spop), .swp (swp), .srp (srp), .spcnt (),
      .spcdrive (spcdrive), .spcenb (), .srcspcpopreal ()
   );

   spc_stack i_stack (
      .clk (clk), .reset (reset), .spush (spush), .spop (spop), .swp (swp),
      .srp (srp), .destspc (destspc), .write_data (write_data),
      .ret_addr (upc_next_inc), .spc_top (spc_top), .spc_ptr ()
   );

   upc_select i_upc (
      .clk (clk), .reset (reset), .state_fetch (state_fetch), .pcs (pcs),
      .target (target), .spc_top (spc_top), .upc (upc), .upc_next_inc (upc_next_inc)
   );

   assign spc_data = spcdrive ? spc_top : '0;
   assign fetch    = state_fetch;

endmodule

// File: tb/useq_sva.sv
//////////////////////////////////////////////////////////////////////
// bound into seq_control
// no checks while reset is high
//////////////////////////////////////////////////////////////////////
module useq_sva
(
   input logic clk,
   input logic reset,
   input logic state_alu,
   input logic state_write,
   input logic state_fetch,
   input logic trap,
   input logic spush,
   input logic spop,
   input logic swp,
   input logic nop
);
   timeunit 1ns;
   timeprecision 100ps;

   a_one_state : assert property (@(posedge clk) disable iff (reset)
      $onehot({state_alu, state_write, state_fetch}))
      else $error("cycle strobes are not one-hot");

   a_push_pop : assert property (@(posedge clk) disable iff (reset) !(spush && spop))
      else $error("stack push and pop in the same word");

   // write cycle is followed by the fetch that moves the pointer
   a_swp_write : assert property (@(posedge clk) disable iff (reset)
      swp |=> (state_fetch && spush))
      else $error("stack write not followed by its push in the fetch cycle");

   // trap in fetch cancels the following word
   a_trap_nop : assert property (@(posedge clk) disable iff (reset)
      (trap && state_fetch) |=> nop)
      else $error("word after a trap is not cancelled");

endmodule

bind seq_control useq_sva i_sva (
   .clk         (clk),
   .reset       (reset),
   .state_alu   (state_alu),
   .state_write (state_write),
   .state_fetch (state_fetch),
   .trap        (trap),
   .spush       (spush),
   .spop        (spop),
   .swp         (swp),
   .nop         (nop)
);

// File: tb/useq_tb.sv
//////////////////////////////////////////////////////////////////////
// cases come from tb/useq_cases.txt
// at most 64 case lines are read
// the testbench stands in for the control store
//////////////////////////////////////////////////////////////////////
`include "useq_config.svh"

module useq_tb
   import useq_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int max_cases     = 64;
   localparam int fetch_timeout = 10;    // clocks
   // bits that no field of the word decodes
   localparam uinst_t dont_care = 49'h1_e040_fc00_0038;

   logic   clk;
   logic   reset;
   logic   trap;
   uinst_t uinst;
   cond_t  cond_flags;
   upc_t   write_data;
   upc_t   upc;
   upc_t   spc_data;
   logic   nop;
   logic   fetch;

   int     case_id    [max_cases];
   uinst_t case_word  [max_cases];
   cond_t  case_cond  [max_cases];
   logic   case_trap  [max_cases];
   upc_t   case_wdata [max_cases];
   upc_t   case_upc   [max_cases];
   logic   case_nop   [max_cases];
   upc_t   case_spc   [max_cases];

   int     n_cases;
   int     seed = 54;
   int     test_errors;
   int     fail_count;
   bit     timed_out;

   useq_top i_dut (
      .clk        (clk),
      .reset      (reset),
      .trap       (trap),
      .uinst      (uinst),
      .cond_flags (cond_flags),
      .write_data (write_data),
      .upc        (upc),
      .spc_data   (spc_data),
      .nop        (nop),
      .fetch      (fetch)
   );

   always #5 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // case file and stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic load_cases();
      int         fd;
      int         got;
      string      line;
      int         id;
      uinst_t     word;
      cond_t      flags;
      logic [3:0] trap_v;
      logic [3:0] nop_v;
      upc_t       wdata;
      upc_t       exp_upc;
      upc_t       exp_spc;
      n_cases = 0;
      fd = $fopen("tb/useq_cases.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open tb/useq_cases.txt");
         return;
      end
      while (!$feof(fd) && n_cases < max_cases)
      begin
         line = "";
         got  = $fgets(line, fd);
         if (got > 0 && line[0] != "#")   // skip column notes
         begin
            got = $sscanf(line, "%d %h %h %h %h %h %h %h", id, word, flags,
                          trap_v, wdata, exp_upc, nop_v, exp_spc);
            if (got == 8)
            begin
               case_id[n_cases]    = id;
               case_word[n_cases]  = word;
               case_cond[n_cases]  = flags;
               case_trap[n_cases]  = trap_v[0];
               case_wdata[n_cases] = wdata;
               case_upc[n_cases]   = exp_upc;
               case_nop[n_cases]   = nop_v[0];
               case_spc[n_cases]   = exp_spc;
               n_cases++;
            end
         end
      end
      $fclose(fd);
   endtask

   // past the last case the inputs go idle
   task automatic drive_case(input int idx);
      logic [63:0] rnd;
      rnd = {$random(seed), $random(seed)};
      if (idx < n_cases)
      begin
         uinst      <= (case_word[idx] & ~dont_care) | (rnd[`UINST_WIDTH-1:0] & dont_care);
         cond_flags <= case_cond[idx];
         trap       <= case_trap[idx];
         write_data <= case_wdata[idx];
      end
      else
      begin
         uinst      <= '0;
         cond_flags <= '0;
         trap       <= 1'b0;
         write_data <= '0;
      end
   endtask

   task automatic wait_fetch(output bit found, output int clocks);
      found  = 1'b0;
      clocks = 0;
      while (!found && clocks < fetch_timeout)
      begin
         @(negedge clk);
         found = fetch;
         clocks++;
      end
   endtask

   task automatic check_value(input string name, input int idx,
                              input upc_t expected, input upc_t actual);
      assert (actual === expected)
      else
      begin
         $display("MISMATCH time %0t test %0d %s expected %h got %h",
                  $time, case_id[idx], name, expected, actual);
         test_errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      int i;
      bit found;
      int clocks;
      clk        = 1'b0;
      reset      = 1'b1;
      trap       = 1'b0;
      uinst      = '0;
      cond_flags = '0;
      write_data = '0;
      fail_count = 0;
      timed_out  = 1'b0;
      load_cases();
      if (n_cases == 0)
         $display("no test cases were read");
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      drive_case(0);   // first word during the first alu cycle
      for (i = 0; i < n_cases && !timed_out; i++)
      begin
         test_errors = 0;
         wait_fetch(found, clocks);
         if (!found)
         begin
            $display("test %0d: no fetch strobe within %0d clocks", case_id[i], fetch_timeout);
            timed_out = 1'b1;
         end
         else
         begin
            // a word lasts 3 clocks and the upc check already used one
            check_value("fetch", i, upc_t'((i == 0) ? 3 : 2), upc_t'(clocks));
            check_value("nop", i, upc_t'(case_nop[i]), upc_t'(nop));
            check_value("spc_data", i, case_spc[i], spc_data);
            @(posedge clk);               // upc loads at the end of fetch
            drive_case(i + 1);
            @(negedge clk);
            check_value("upc", i, case_upc[i], upc);
            if (test_errors == 0)
               $display("test %0d ok", case_id[i]);
            else
            begin
               $display("test %0d FAIL", case_id[i]);
               fail_count++;
            end
         end
      end
      $display("%0d tests run, %0d with errors", n_cases, fail_count);
      if (n_cases > 0 && fail_count == 0 && !timed_out)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: tb/useq_cases.txt
# id uinst(hex) cond_flags trap write_data | expected: upc_after_fetch nop spc_data_in_fetch
# uinst holds zeros in the don't-care bits, the testbench fills them
1  0000000000000 00 0 0000 0001 0 0000
2  0000000000000 00 0 0000 0002 0 0000
3  0080000100003 08 0 0000 0100 0 0000
4  0080000200003 00 0 0000 0101 0 0000
5  0080000200045 00 0 0000 0200 0 0000
6  0080000300045 20 0 0000 0201 0 0000
7  0080000300100 01 0 0000 0300 0 0000
8  0000100000000 00 0 0000 0301 0 0202
9  0080000000200 01 0 0000 0202 0 0000
10 0080000400100 01 0 0000 0400 0 0000
11 0040000000000 00 0 0000 0203 0 0000
12 0000800000000 00 0 1234 0204 0 0000
13 0000200000000 00 0 0000 0205 0 1234
14 0080000500081 02 0 0000 0500 0 0000
15 0000000000000 00 0 0000 0501 1 0000
16 0120000600000 00 0 0000 0600 0 0000
17 0040000000000 00 0 0000 0601 1 0000
18 0000000000000 00 1 0000 0602 1 0000
19 0000000000000 00 0 0000 0603 1 0000
20 0000000000000 00 0 0000 0604 0 0000
21 0110000700000 00 0 0000 0700 0 0000
22 0108000800000 00 0 0000 0605 0 0000
23 0118000900000 00 0 0000 0606 0 0000
24 0080000a00382 04 0 0000 0a00 0 0000
25 0000000000000 00 0 0000 0607 1 0000
26 0000000000000 00 0 0000 0608 1 0000
27 0000000000000 00 0 0000 0609 0 0000
28 0000000000800 00 0 0000 060a 1 0000
29 0000000000000 00 0 0000 060b 0 0000

// File: compile.f
+incdir+logic
logic/useq_pkg.sv
logic/cycle_sequencer.sv
logic/uinst_decode.sv
logic/seq_control.sv
logic/spc_stack.sv
logic/upc_select.sv
logic/useq_top.sv
tb/useq_sva.sv
tb/useq_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of useq_tb, exit status 0 only on a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   -f compile.f --top-module useq_tb -Mdir obj_dir -o useq_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "verilator build failed, see build.log"
   exit 1
fi

./obj_dir/useq_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation ended with an error status, see sim.log"
   exit 1
fi

if grep -qx "all tests passed" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL, see sim.log"
exit 1
